//--- build.f
logic/memory_bus_pkg.sv
logic/cpu_control_pkg.sv
logic/cpu_memory_interface.sv
logic/dma_copy_engine.sv
logic/bank_arbiter.sv
logic/banked_memory.sv
logic/memory_subsystem.sv
testbench/tb_checker.sv
testbench/tb_memory_subsystem.sv

//--- logic/bank_arbiter.sv
// Per-bank grant between the CPU and DMA masters with sticky ownership and read-data routing
`default_nettype none

module bank_arbiter (
	input wire logic CLK,
	input wire logic RSTb,
	input wire memory_bus_pkg::mem_request_t requests [cpu_control_pkg::master_count],
	output logic [cpu_control_pkg::master_count-1:0] grants,
	output memory_bus_pkg::mem_response_t responses [cpu_control_pkg::master_count],
	output memory_bus_pkg::bank_request_t bank_requests [memory_bus_pkg::bank_count],
	input wire memory_bus_pkg::word_t bank_read_data [memory_bus_pkg::bank_count]
);
	import memory_bus_pkg::*;
	import cpu_control_pkg::*;

	logic [bank_count-1:0] want [master_count]; // One hot bank each master targets
	logic [bank_count-1:0] owned [master_count]; // Banks held by each master
	logic [bank_count-1:0] held; // Bank has an owner
	logic [bank_count-1:0] held_next;
	logic [bank_count-1:0] active; // Owner still targets the bank, an access happens
	master_index_t owner [bank_count]; // Kept after release, so it also names the last served
	master_index_t owner_next [bank_count];
	bank_index_t read_bank [master_count]; // Bank of the read accepted last cycle
	logic [master_count-1:0] read_pending;

	always_comb begin
		for (int m = 0; m < master_count; m++) begin
			want[m] = '0;
			want[m][bank_of(requests[m].address)] = requests[m].valid;
			for (int b = 0; b < bank_count; b++)
				owned[m][b] = held[b] && owner[b] == master_index_t'(m);
			grants[m] = |(owned[m] & want[m]); // Ownership qualified by the current target
		end
		for (int b = 0; b < bank_count; b++)
			active[b] = held[b] && want[owner[b]][b];
	end

	// Search starts after the last owner, so the other master wins a contended bank
	always_comb begin
		master_index_t candidate;
		for (int b = 0; b < bank_count; b++) begin
			held_next[b] = active[b];
			owner_next[b] = owner[b];
			for (int k = 1; k <= master_count; k++) begin
				candidate = master_index_t'((int'(owner[b]) + k) % master_count);
				if (!held_next[b] && want[candidate][b]) begin
					held_next[b] = 1'b1;
					owner_next[b] = candidate;
				end
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			held <= '0;
			owner <= '{default: master_dma}; // CPU wins the first contention
			read_pending <= '0;
		end else begin
			held <= held_next;
			owner <= owner_next;
			for (int m = 0; m < master_count; m++)
				read_pending[m] <= grants[m] && !requests[m].wr;
		end
	end

	always_ff @(posedge CLK) begin
		for (int m = 0; m < master_count; m++)
			if (grants[m])
				read_bank[m] <= bank_of(requests[m].address);
	end

	always_comb begin
		for (int b = 0; b < bank_count; b++) begin
			bank_requests[b].enable = active[b];
			bank_requests[b].wr = requests[owner[b]].wr;
			bank_requests[b].offset = requests[owner[b]].address[bank_offset_bits-1:0];
			bank_requests[b].write_data = requests[owner[b]].write_data;
		end
		for (int m = 0; m < master_count; m++) begin
			responses[m].read_valid = read_pending[m];
			responses[m].read_data = bank_read_data[read_bank[m]];
		end
	end

	for (genvar m = 0; m < master_count; m++) begin : g_master_check
		assert property (@(posedge CLK) disable iff (!RSTb) $onehot0(owned[m]))
			else $error("Master %0d owns more than one bank", m);
	end

	for (genvar b = 0; b < bank_count; b++) begin : g_bank_check
		// Both masters newly asking for a free bank, the one not served last takes it
		assert property (@(posedge CLK) disable iff (!RSTb)
			(!held[b] && want[master_cpu][b] && want[master_dma][b])
			|=> held[b] && owner[b] != $past(owner[b]))
			else $error("Bank %0d contention not won by the master served less recently", b);
	end

endmodule

`default_nettype wire

//--- logic/banked_memory.sv
// Four single-port word RAM banks with registered read data, driven by the bank arbiter
`default_nettype none

module banked_memory (
	input wire logic CLK,
	input wire memory_bus_pkg::bank_request_t bank_requests [memory_bus_pkg::bank_count],
	output memory_bus_pkg::word_t bank_read_data [memory_bus_pkg::bank_count]
);
	import memory_bus_pkg::*;

	for (genvar b = 0; b < bank_count; b++) begin : g_bank
		word_t storage [2**bank_offset_bits]; // One bank, 16K words

		// Read data holds its value until the next read of this bank
		always_ff @(posedge CLK) begin
			if (bank_requests[b].enable) begin
				if (bank_requests[b].wr)
					storage[bank_requests[b].offset] <= bank_requests[b].write_data;
				else
					bank_read_data[b] <= storage[bank_requests[b].offset];
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/cpu_control_pkg.sv
// CPU memory-interface state encoding and bus master indices used by the top level and the arbiter
`default_nettype none

package cpu_control_pkg;

	// Wait states 1 and 2 form the bank switch penalty for each access kind
	typedef enum logic [3:0] {
		state_halt = 4'd0, // Asleep, nothing is fetched
		state_execute = 4'd1, // Fetching and executing non-memory instructions
		state_wait_ready1 = 4'd2, // First penalty cycle on a fetch bank switch
		state_wait_ready2 = 4'd3, // Waiting for the grant of the new fetch bank
		state_execute_load = 4'd4, // Performing loads
		state_wait_load1 = 4'd5, // First penalty cycle before a load in another bank
		state_wait_load2 = 4'd6, // Waiting for the grant of the load bank
		state_execute_store = 4'd7, // Performing stores
		state_wait_store1 = 4'd8, // First penalty cycle before a store in another bank
		state_wait_store2 = 4'd9 // Waiting for the grant of the store bank
	} cpu_mem_state_t;

	localparam int master_count = 2; // CPU and DMA

	typedef logic [$clog2(master_count)-1:0] master_index_t;

	localparam master_index_t master_cpu = master_index_t'(0); // Port 0 of the arbiter
	localparam master_index_t master_dma = master_index_t'(1); // Port 1 of the arbiter

endpackage

`default_nettype wire

//--- logic/cpu_memory_interface.sv
// CPU side bus master that sequences fetches, loads and stores and pays wait states on bank switches
`default_nettype none

module cpu_memory_interface (
	input wire logic CLK,
	input wire logic RSTb,
	input wire logic load_memory, // Next access is a load
	input wire logic store_memory, // Next access is a store
	input wire logic halt, // Put the CPU to sleep
	input wire logic wake, // Leave the halt state
	input wire memory_bus_pkg::address_t pc, // Fetch address from the core
	input wire memory_bus_pkg::address_t load_store_address,
	input wire memory_bus_pkg::word_t store_data,
	input wire logic memory_ready, // Grant level from the arbiter
	output memory_bus_pkg::mem_request_t memory_request,
	output logic is_executing,
	output logic is_fetching
);
	import memory_bus_pkg::*;
	import cpu_control_pkg::*;

	cpu_mem_state_t state;
	cpu_mem_state_t state_next;
	address_t address_r; // Address currently presented to the arbiter
	address_t next_address;
	logic bank_switch; // Next address lives in another bank

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			state <= state_wait_ready1; // Comes out of reset fetching from address zero
			address_r <= '0;
		end else begin
			state <= state_next;
			address_r <= next_address;
		end
	end

	// A new address is only taken while an instruction executes
	always_comb begin
		next_address = address_r;
		if (is_executing)
			next_address = (load_memory || store_memory) ? load_store_address : pc;
	end

	assign bank_switch = bank_of(next_address) != bank_of(address_r);

	always_comb begin
		state_next = state;
		case (state)
			state_halt:
				if (wake)
					state_next = state_wait_ready1; // Re-enter through the fetch penalty
			state_execute:
				if (halt)
					state_next = state_halt;
				else if (load_memory)
					state_next = bank_switch ? state_wait_load1 : state_execute_load;
				else if (store_memory)
					state_next = bank_switch ? state_wait_store1 : state_execute_store;
				else if (bank_switch)
					state_next = state_wait_ready1;
			state_wait_ready1:
				state_next = state_wait_ready2;
			state_wait_ready2:
				if (memory_ready)
					state_next = state_execute;
			state_execute_load:
				if (!load_memory)
					state_next = bank_switch ? state_wait_ready1 : state_execute;
				else if (bank_switch)
					state_next = state_wait_load1; // Back to back load into another bank
			state_wait_load1:
				state_next = state_wait_load2;
			state_wait_load2:
				if (memory_ready)
					state_next = state_execute_load;
			state_execute_store:
				if (!store_memory)
					state_next = bank_switch ? state_wait_ready1 : state_execute;
				else if (bank_switch)
					state_next = state_wait_store1;
			state_wait_store1:
				state_next = state_wait_store2;
			state_wait_store2:
				if (memory_ready)
					state_next = state_execute_store;
			default:
				state_next = state_halt;
		endcase
	end

	assign is_executing = state inside {state_execute, state_execute_load, state_execute_store};
	assign is_fetching = state == state_execute;

	// Valid is dropped only in halt and in the first penalty cycle
	always_comb begin
		memory_request.valid = 1'b0;
		memory_request.wr = 1'b0;
		case (state)
			state_execute, state_wait_ready2, state_execute_load, state_wait_load2:
				memory_request.valid = 1'b1;
			state_execute_store, state_wait_store2: begin
				memory_request.valid = 1'b1;
				memory_request.wr = 1'b1;
			end
			default: ;
		endcase
		memory_request.address = address_r;
		memory_request.write_data = store_data;
	end

	// Execute states are only entered with a grant, which stays while the bank stays the same
	assert property (@(posedge CLK) disable iff (!RSTb) is_executing |-> memory_ready)
		else $error("CPU executing without the grant of its bank");

endmodule

`default_nettype wire

//--- logic/dma_copy_engine.sv
// Second bus master that copies a block of words from a source to a destination address
`default_nettype none

module dma_copy_engine (
	input wire logic CLK,
	input wire logic RSTb,
	input wire logic start, // Single cycle pulse, ignored while busy
	input wire memory_bus_pkg::address_t source_address,
	input wire memory_bus_pkg::address_t destination_address,
	input wire logic [memory_bus_pkg::bank_offset_bits-1:0] word_count,
	output memory_bus_pkg::mem_request_t memory_request,
	input wire logic memory_ready, // Grant level from the arbiter
	input wire memory_bus_pkg::mem_response_t memory_response,
	output logic busy,
	output logic done // One cycle pulse after the last write
);
	import memory_bus_pkg::*;

	typedef enum logic [1:0] {
		dma_idle,
		dma_read, // Read request toward the source word
		dma_wait_response, // Valid dropped until the read data strobe
		dma_write // Write request toward the destination word
	} dma_state_t;

	dma_state_t state;
	address_t source_r;
	address_t destination_r;
	logic [bank_offset_bits-1:0] remaining; // Words still to copy, including the current one
	word_t copy_word; // Word in flight between read and write

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			state <= dma_idle;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				dma_idle:
					if (start && word_count != '0)
						state <= dma_read; // A zero length start does nothing
				dma_read:
					if (memory_ready)
						state <= dma_wait_response;
				dma_wait_response:
					if (memory_response.read_valid)
						state <= dma_write;
				dma_write:
					if (memory_ready) begin
						state <= (remaining == 1) ? dma_idle : dma_read;
						done <= remaining == 1;
					end
				default:
					state <= dma_idle;
			endcase
		end
	end

	// Block parameters are sampled every idle cycle so the start edge captures them
	always_ff @(posedge CLK) begin
		if (state == dma_idle) begin
			source_r <= source_address;
			destination_r <= destination_address;
			remaining <= word_count;
		end else if (state == dma_write && memory_ready) begin
			source_r <= source_r + 1'b1;
			destination_r <= destination_r + 1'b1;
			remaining <= remaining - 1'b1;
		end
		if (state == dma_wait_response && memory_response.read_valid)
			copy_word <= memory_response.read_data;
	end

	always_comb begin
		memory_request.valid = state == dma_read || state == dma_write;
		memory_request.wr = state == dma_write;
		memory_request.address = (state == dma_write) ? destination_r : source_r;
		memory_request.write_data = copy_word;
	end

	assign busy = state != dma_idle;

	// A start from idle never lands in the cycle of the previous done pulse
	assert property (@(posedge CLK) disable iff (!RSTb) (start && !busy) |-> !done)
		else $error("DMA started in the same cycle as done");

endmodule

`default_nettype wire

//--- logic/memory_bus_pkg.sv
// Shared bus widths, bank split and request/response types for the masters, arbiter and RAM banks
`default_nettype none

package memory_bus_pkg;

	localparam int address_bits = 16; // Word address, no byte addressing
	localparam int data_bits = 16; // One memory word
	localparam int bank_count = 4; // Banks selected by the top address bits
	localparam int bank_select_bits = 2; // Top bits of the address pick the bank
	localparam int bank_offset_bits = 14; // Word index inside one bank

	typedef logic [address_bits-1:0] address_t;
	typedef logic [data_bits-1:0] word_t;
	typedef logic [bank_select_bits-1:0] bank_index_t;
	typedef logic [bank_offset_bits-1:0] bank_offset_t;

	// What a master drives toward the arbiter
	typedef struct packed {
		logic valid; // Held until the access is granted
		logic wr; // Store when high, read when low
		address_t address; // Full word address, bank in the top bits
		word_t write_data; // Only meaningful with wr
	} mem_request_t;

	// What one bank sees after arbitration
	typedef struct packed {
		logic enable; // An access takes place this edge
		logic wr; // Write the word, otherwise register a read
		bank_offset_t offset; // Word inside the bank
		word_t write_data;
	} bank_request_t;

	// Read data back to a master, one cycle after the accepted read
	typedef struct packed {
		logic read_valid; // Single cycle strobe
		word_t read_data;
	} mem_response_t;

	// Bank that an address falls into
	function automatic bank_index_t bank_of(input address_t address);
		return address[address_bits-1 -: bank_select_bits];
	endfunction

endpackage

`default_nettype wire

//--- logic/memory_subsystem.sv
// Top level of the memory side, joining the CPU interface, DMA engine, arbiter and RAM banks
`default_nettype none

module memory_subsystem (
	input wire logic CLK,
	input wire logic RSTb,
	input wire logic load_memory,
	input wire logic store_memory,
	input wire logic halt,
	input wire logic wake,
	input wire memory_bus_pkg::address_t pc,
	input wire memory_bus_pkg::address_t load_store_address,
	input wire memory_bus_pkg::word_t store_data,
	input wire logic dma_start,
	input wire memory_bus_pkg::address_t source_address,
	input wire memory_bus_pkg::address_t destination_address,
	input wire logic [memory_bus_pkg::bank_offset_bits-1:0] word_count,
	output logic is_executing,
	output logic is_fetching,
	output memory_bus_pkg::word_t load_data, // Also returns fetched words
	output logic load_valid,
	output logic dma_busy,
	output logic dma_done
);
	import memory_bus_pkg::*;
	import cpu_control_pkg::*;

	mem_request_t requests [master_count]; // Indexed by master_cpu and master_dma
	logic [master_count-1:0] grants;
	mem_response_t responses [master_count];
	bank_request_t bank_requests [bank_count];
	word_t bank_read_data [bank_count];

	cpu_memory_interface u_cpu_memory_interface (
		.CLK(CLK),
		.RSTb(RSTb),
		.load_memory(load_memory),
		.store_memory(store_memory),
		.halt(halt),
		.wake(wake),
		.pc(pc),
		.load_store_address(load_store_address),
		.store_data(store_data),
		.memory_ready(grants[master_cpu]),
		.memory_request(requests[master_cpu]),
		.is_executing(is_executing),
		.is_fetching(is_fetching)
	);

	dma_copy_engine u_dma_copy_engine (
		.CLK(CLK),
		.RSTb(RSTb),
		.start(dma_start),
		.source_address(source_address),
		.destination_address(destination_address),
		.word_count(word_count),
		.memory_request(requests[master_dma]),
		.memory_ready(grants[master_dma]),
		.memory_response(responses[master_dma]),
		.busy(dma_busy),
		.done(dma_done)
	);

	bank_arbiter u_bank_arbiter (
		.CLK(CLK),
		.RSTb(RSTb),
		.requests(requests),
		.grants(grants),
		.responses(responses),
		.bank_requests(bank_requests),
		.bank_read_data(bank_read_data)
	);

	banked_memory u_banked_memory (
		.CLK(CLK),
		.bank_requests(bank_requests),
		.bank_read_data(bank_read_data)
	);

	assign load_data = responses[master_cpu].read_data;
	assign load_valid = responses[master_cpu].read_valid;

endmodule

`default_nettype wire

//--- testbench/tb_checker.sv
// Testbench checker that mirrors the CPU address register, holds the reference memory and compares load data and flags
`default_nettype none

module tb_checker (
	input wire logic CLK,
	input wire logic RSTb,
	input wire logic load_memory,
	input wire logic store_memory,
	input wire memory_bus_pkg::address_t pc,
	input wire memory_bus_pkg::address_t load_store_address,
	input wire logic is_executing,
	input wire logic is_fetching,
	input wire memory_bus_pkg::word_t load_data,
	input wire logic load_valid,
	input wire logic dma_busy,
	input wire logic dma_done
);
	timeunit 1ns;
	timeprecision 100ps;
	import memory_bus_pkg::*;

	word_t model [2**address_bits]; // Reference memory, unwritten words stay unknown
	address_t address_mirror; // Follows the address the CPU interface presents
	address_t read_address; // Address presented at the last edge, its data comes back now
	logic mirror_is_load; // The mirrored address was taken from a load command
	logic load_due; // A load was performed at the last edge, so its data strobe is due now
	logic copy_running; // A DMA copy was started and its done pulse has not been seen yet
	int check_count; // Load data comparisons made
	int error_count;
	int errors_before; // Errors counted when the previous test finished

	// A new address is taken on every edge where an instruction executes
	always @(posedge CLK) begin
		if (!RSTb) begin
			address_mirror <= '0;
			mirror_is_load <= 1'b0;
		end else if (is_executing) begin
			address_mirror <= (load_memory || store_memory) ? load_store_address : pc;
			mirror_is_load <= load_memory;
		end
		read_address <= address_mirror;
		// Loads and stores are performed on edges that execute without fetching
		load_due <= RSTb && is_executing && !is_fetching && mirror_is_load;
	end

	// Busy runs from an accepted start until the done pulse
	always @(posedge CLK) begin
		if (!RSTb)
			copy_running <= 1'b0;
		else if (dma_start_seen())
			copy_running <= 1'b1;
		else if (dma_done)
			copy_running <= 1'b0;
	end

	// Registered outputs are settled at the falling edge
	always @(negedge CLK) begin
		if (RSTb && load_valid) begin
			check_count++;
			if (load_data !== model[read_address]) begin
				error_count++;
				$display("CHECK FAILED load_data at address %h: expected %h got %h",
					read_address, model[read_address], load_data);
			end
		end
		if (RSTb && load_due && load_valid !== 1'b1) begin
			error_count++;
			$display("CHECK FAILED load_valid: expected %h got %h", 1'b1, load_valid);
		end
		if (RSTb && is_fetching && !is_executing) begin
			error_count++;
			$display("CHECK FAILED is_executing: expected %h got %h", 1'b1, is_executing);
		end
		if (RSTb && dma_busy !== (copy_running && !dma_done)) begin
			error_count++; // Done comes with the return to idle
			$display("CHECK FAILED dma_busy: expected %h got %h",
				copy_running && !dma_done, dma_busy);
		end
	end

	function automatic logic dma_start_seen();
		return tb_memory_subsystem.dma_start && !copy_running;
	endfunction

	function automatic void write_word(input address_t address, input word_t data);
		model[address] = data;
	endfunction

	function automatic word_t read_word(input address_t address);
		return model[address];
	endfunction

	// Failures seen by the stimulus side are added in as a running total
	task automatic finish_test(input string name, input int stimulus_failures);
		int total;
		total = error_count + stimulus_failures;
		$display("Test %s finished with %0d errors", name, total - errors_before);
		errors_before = total;
	endtask

endmodule

`default_nettype wire

//--- testbench/tb_memory_subsystem.sv
// Testbench top that plays the CPU core and the DMA user with LFSR stimulus and prints the summary
`default_nettype none

module tb_memory_subsystem;
	timeunit 1ns;
	timeprecision 100ps;
	import memory_bus_pkg::*;

	logic CLK = 1'b0;
	logic RSTb;
	logic load_memory, store_memory, halt, wake, dma_start;
	address_t pc, load_store_address, source_address, destination_address;
	word_t store_data, load_data;
	logic [bank_offset_bits-1:0] word_count;
	logic is_executing, is_fetching, load_valid, dma_busy, dma_done;
	logic [31:0] lfsr_state = 32'ha238_d642;
	int tb_failures; // Timeouts and protocol failures seen here
	int test_count;
	address_t stored [$]; // Addresses the CPU has written
	address_t src, dst;
	int len, stalls;

	always #4 CLK = ~CLK; // 8 ns period

	memory_subsystem i_dut (.*);
	tb_checker i_checker (.*);

	// Galois LFSR, one step per bit taken
	function automatic logic [31:0] random_bits(input int count);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < count; i++) begin
			lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'ha300_0000 : lfsr_state >> 1;
			value = {value[30:0], lfsr_state[0]};
		end
		return value;
	endfunction

	// Data words sit at offsets 0x1000 to 0x1fff, fetches stay below 0x100 in bank 0
	function automatic address_t data_address(input bank_index_t bank);
		logic [11:0] offset;
		offset = random_bits(12);
		return {bank, 2'b01, offset};
	endfunction

	function automatic logic flag_value(input int which);
		case (which)
			0: return is_executing;
			1: return is_fetching;
			2: return dma_done;
			default: return dma_busy;
		endcase
	endfunction

	task automatic next_cycle;
		@(posedge CLK);
		#1; // Inputs change and outputs are read 1 ns after the edge
	endtask

	task automatic wait_until(input string what, input int which, input logic level, input int limit);
		int cycles = 0;
		while (flag_value(which) !== level && cycles < limit) begin
			next_cycle();
			cycles++;
		end
		if (flag_value(which) !== level) begin
			$display("Timed out waiting for %s", what);
			tb_failures++;
		end
	endtask

	// One load or store, held until the CPU interface reaches the matching execute state
	task automatic cpu_access(input logic is_store, input address_t address, input word_t data,
		output int stall_cycles);
		int cycles = 0;
		stall_cycles = 0;
		pc = address_t'(random_bits(8));
		load_store_address = address;
		store_data = data;
		store_memory = is_store;
		load_memory = !is_store;
		do begin
			next_cycle();
			cycles++;
			if (!is_executing)
				stall_cycles++;
		end while (!(is_executing && !is_fetching) && cycles < 200);
		store_memory = 1'b0; // The access itself lands on the next edge
		load_memory = 1'b0;
		if (!(is_executing && !is_fetching)) begin
			$display("CPU access to address %h was never performed", address);
			tb_failures++;
		end else if (is_store)
			i_checker.write_word(address, data);
		wait_until("fetching after a CPU access", 1, 1'b1, 200);
	endtask

	task automatic random_cpu_op(input bank_index_t bank);
		int unused;
		address_t address;
		if (stored.size() == 0 || random_bits(1)) begin
			address = data_address(bank);
			cpu_access(1'b1, address, word_t'(random_bits(16)), unused);
			stored.push_back(address);
		end else
			cpu_access(1'b0, stored[random_bits(6) % stored.size()], '0, unused);
	endtask

	task automatic fill_words(input address_t base, input int count);
		int unused;
		for (int i = 0; i < count; i++)
			cpu_access(1'b1, address_t'(base + i), word_t'(random_bits(16)), unused);
	endtask

	task automatic load_words(input address_t base, input int count);
		int unused;
		for (int i = 0; i < count; i++)
			cpu_access(1'b0, address_t'(base + i), '0, unused);
	endtask

	task automatic start_copy(input address_t from, input address_t to, input int count);
		source_address = from;
		destination_address = to;
		word_count = count;
		dma_start = 1'b1;
		next_cycle();
		dma_start = 1'b0;
	endtask

	task automatic wait_copy(input address_t from, input address_t to, input int count);
		wait_until("DMA done", 2, 1'b1, 3000);
		for (int i = 0; i < count; i++)
			i_checker.write_word(address_t'(to + i), i_checker.read_word(address_t'(from + i)));
	endtask

	task automatic end_test(input string name);
		test_count++;
		i_checker.finish_test(name, tb_failures);
	endtask

	initial begin
		{RSTb, load_memory, store_memory, halt, wake, dma_start} = '0;
		{pc, load_store_address, store_data, source_address, destination_address} = '0;
		word_count = '0;
		repeat (8) next_cycle();
		RSTb = 1'b1;

		wait_until("is_executing after reset", 0, 1'b1, 50);
		if (!is_fetching) begin
			$display("CHECK FAILED is_fetching: expected %h got %h", 1'b1, is_fetching);
			tb_failures++;
		end
		end_test("reset fetch");

		repeat (40) random_cpu_op(bank_index_t'(random_bits(2)));
		end_test("random loads and stores");

		src = data_address(2'd3); // Fetches run in bank 0, so this store switches banks
		cpu_access(1'b1, src, word_t'(random_bits(16)), stalls);
		if (stalls < 2) begin
			$display("Store across a bank boundary skipped the wait states");
			tb_failures++;
		end
		cpu_access(1'b0, src, '0, stalls);
		end_test("bank switch store");

		halt = 1'b1;
		wait_until("is_executing to drop on halt", 0, 1'b0, 50);
		halt = 1'b0;
		repeat (1 + random_bits(4)) begin
			next_cycle();
			if (is_executing || is_fetching) begin
				$display("CPU left halt without wake");
				tb_failures++;
			end
		end
		wake = 1'b1;
		next_cycle();
		wake = 1'b0;
		wait_until("is_executing after wake", 0, 1'b1, 50);
		end_test("halt and wake");

		len = 1 + random_bits(4);
		src = {4'b1010, 12'(random_bits(11))}; // Bank 2, offsets from 0x2000
		dst = {4'b1110, 12'(random_bits(11))}; // Bank 3, offsets from 0x2000
		fill_words(src, len);
		start_copy(src, dst, len);
		start_copy(src, stored[0], 5); // Lands while busy and must be dropped
		wait_copy(src, dst, len);
		load_words(dst, len);
		cpu_access(1'b0, stored[0], '0, stalls);
		end_test("DMA copy across banks");

		len = 1 + random_bits(4);
		src = {4'b0110, 12'(random_bits(11))}; // Both ends of the copy in bank 1
		dst = {4'b0111, 12'(random_bits(11))};
		fill_words(src, len);
		start_copy(src, dst, len);
		fork
			wait_copy(src, dst, len);
			repeat (16) random_cpu_op(2'd1);
		join
		load_words(dst, len);
		end_test("shared bank contention");

		$display("%0d tests, %0d load checks, %0d errors", test_count, i_checker.check_count,
			i_checker.error_count + tb_failures);
		if (i_checker.error_count + tb_failures == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire
